//--- vlog.f
logic/regbank_pkg.sv
logic/access_pkg.sv
logic/cpu_req_stage.sv
logic/access_mode_fsm.sv
logic/rww_reg.sv
logic/rdata_stage.sv
logic/regbank_top.sv
bench/regbank_properties.sv
bench/regbank_checker.sv
bench/tb_regbank.sv

//--- Makefile
# Verilator build, run and lint for the register bank

VERILATOR ?= verilator
TB_TOP    ?= tb_regbank
RTL_TOP   ?= regbank_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Finished with errors
RTL_FILES ?= $(filter logic/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/tb_regbank.sv
/*
 * tb_regbank
 * drives CPU traffic, mode pulses and logic loads into the control
 * register bank and checks it against a cycle model of the registers
 */
module tb_regbank
    import regbank_pkg::*, access_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_HALF  = 20;
    localparam int          DRIVE_DLY = 2;
    localparam int          WAIT_MAX  = 20;
    localparam logic [31:0] SEED      = 32'hc96c240e;
    // mode pulse kinds
    localparam int          P_EFUSE_DONE = 0;
    localparam int          P_TEST_ENTRY = 1;
    localparam int          P_TEST_EXIT  = 2;

    logic         clk = 1'b0;
    logic         rst_n = 1'b0;
    logic         wen;
    logic         ren;
    reg_addr_t    addr;
    reg_data_t    wdata;
    logic         spi_en;
    logic         efuse_done;
    logic         test_entry;
    logic         test_exit;
    reg_data_t    stat_lgc_wen;
    reg_data_t    stat_lgc_wdata;
    reg_data_t    trim_lgc_wen;
    reg_data_t    trim_lgc_wdata;
    reg_data_t    rdata;
    logic         rdata_vld;
    reg_data_t    ctrl;
    reg_data_t    trim;
    reg_data_t    gain;
    reg_data_t    stat;
    access_mode_e mode;

    // model copy of the registers in address order
    reg_data_t    model_regs [4];
    access_mode_e model_mode;
    logic         cap_wen;
    logic         cap_ren;
    reg_addr_t    cap_addr;
    reg_data_t    cap_wdata;
    logic         exp_push;
    reg_data_t    exp_rdata;

    int           chk_errors;
    int           timeouts;
    int           assert_fails;
    logic [31:0]  rng_state;

    always #CLK_HALF clk = ~clk;

    regbank_top u_regbank_top (
        .i_clk            (clk),
        .i_rst_n          (rst_n),
        .i_wen            (wen),
        .i_ren            (ren),
        .i_addr           (addr),
        .i_wdata          (wdata),
        .i_spi_en         (spi_en),
        .i_efuse_done     (efuse_done),
        .i_test_entry     (test_entry),
        .i_test_exit      (test_exit),
        .i_stat_lgc_wen   (stat_lgc_wen),
        .i_stat_lgc_wdata (stat_lgc_wdata),
        .i_trim_lgc_wen   (trim_lgc_wen),
        .i_trim_lgc_wdata (trim_lgc_wdata),
        .o_rdata          (rdata),
        .o_rdata_vld      (rdata_vld),
        .o_ctrl           (ctrl),
        .o_trim           (trim),
        .o_gain           (gain),
        .o_stat           (stat),
        .o_mode           (mode)
    );

    bind regbank_top regbank_properties u_regbank_properties (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_ren       (i_ren),
        .i_rdata     (o_rdata),
        .i_rdata_vld (o_rdata_vld),
        .i_test_en   (test_en),
        .i_cfg_en    (cfg_en),
        .i_efuse_en  (efuse_en)
    );

    regbank_checker u_regbank_checker (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_dut_ctrl      (ctrl),
        .i_dut_trim      (trim),
        .i_dut_gain      (gain),
        .i_dut_stat      (stat),
        .i_dut_mode      (mode),
        .i_dut_rdata     (rdata),
        .i_dut_rdata_vld (rdata_vld),
        .i_exp_ctrl      (model_regs[0]),
        .i_exp_trim      (model_regs[1]),
        .i_exp_gain      (model_regs[2]),
        .i_exp_stat      (model_regs[3]),
        .i_exp_mode      (model_mode),
        .i_exp_push      (exp_push),
        .i_exp_rdata     (exp_rdata),
        .o_errors        (chk_errors)
    );

    // ====================
    // reference model
    // ====================
    // 4 means unmapped
    function automatic int reg_index(reg_addr_t a);
        return (a < 8'd4) ? int'(a) : 4;
    endfunction

    // permission table by index in register order
    function automatic bit may_write(int idx, access_mode_e m, logic spi);
        case (idx)
            0, 2:    return (m == MODE_TEST) | (m == MODE_CFG) | spi;
            1:       return (m == MODE_TEST) | (m == MODE_EFUSE);
            3:       return (m == MODE_TEST);
            default: return 1'b0;
        endcase
    endfunction

    // eFuse mode never reads
    function automatic bit may_read(int idx, access_mode_e m, logic spi);
        case (idx)
            0, 2, 3: return (m == MODE_TEST) | (m == MODE_CFG) | spi;
            1:       return (m == MODE_TEST) | (m == MODE_CFG);
            default: return 1'b0;
        endcase
    endfunction

    // cpu write first then logic load otherwise hold
    function automatic reg_data_t ref_next(int idx, reg_data_t lgc_en, reg_data_t lgc_data);
        if (cap_wen && reg_index(cap_addr) == idx && may_write(idx, model_mode, spi_en)) begin
            return cap_wdata;
        end
        if (lgc_en != '0) begin
            return lgc_data;
        end
        return model_regs[idx];
    endfunction

    function automatic reg_data_t ref_read(reg_addr_t a);
        int idx;
        idx = reg_index(a);
        if (idx < 4 && may_read(idx, model_mode, spi_en)) begin
            return model_regs[idx];
        end
        return '0;
    endfunction

    function automatic access_mode_e ref_mode(access_mode_e m);
        case (m)
            MODE_EFUSE: return efuse_done ? MODE_CFG : m;
            MODE_CFG:   return test_entry ? MODE_TEST : m;
            MODE_TEST:  return test_exit ? MODE_CFG : m;
            default:    return MODE_EFUSE;
        endcase
    endfunction

    // read resolves on old values before writes, loads and mode move
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            model_regs[0] = DEF_CTRL;
            model_regs[1] = DEF_TRIM;
            model_regs[2] = DEF_GAIN;
            model_regs[3] = DEF_STAT;
            model_mode = MODE_EFUSE;
            cap_wen = 1'b0;
            cap_ren = 1'b0;
            cap_addr = '0;
            cap_wdata = '0;
            exp_push = 1'b0;
            exp_rdata = '0;
        end else begin
            exp_push = cap_ren;
            exp_rdata = cap_ren ? ref_read(cap_addr) : '0;
            model_regs[0] = ref_next(0, '0, '0);
            model_regs[1] = ref_next(1, trim_lgc_wen, trim_lgc_wdata);
            model_regs[2] = ref_next(2, '0, '0);
            model_regs[3] = ref_next(3, stat_lgc_wen, stat_lgc_wdata);
            model_mode = ref_mode(model_mode);
            cap_wen = wen;
            cap_ren = ren;
            cap_addr = addr;
            cap_wdata = wdata;
        end
    end

    // ====================
    // stimulus helpers
    // ====================
    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // everything but the spi level
    task automatic drive_idle();
        wen = 1'b0;
        ren = 1'b0;
        addr = '0;
        wdata = '0;
        efuse_done = 1'b0;
        test_entry = 1'b0;
        test_exit = 1'b0;
        stat_lgc_wen = '0;
        stat_lgc_wdata = '0;
        trim_lgc_wen = '0;
        trim_lgc_wdata = '0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while ((cap_wen || cap_ren || rdata_vld) && n < WAIT_MAX) begin
            next_cycle();
            n++;
        end
        if (cap_wen || cap_ren || rdata_vld) begin
            $display("Timeout at %0t: request pipeline did not drain", $time);
            timeouts++;
        end
    endtask

    task automatic write_reg(reg_addr_t a, reg_data_t d);
        wen = 1'b1;
        addr = a;
        wdata = d;
        next_cycle();
        wen = 1'b0;
    endtask

    task automatic read_and_wait(reg_addr_t a);
        int n;
        ren = 1'b1;
        addr = a;
        next_cycle();
        ren = 1'b0;
        n = 0;
        do begin
            next_cycle();
            n++;
        end while (!rdata_vld && n < WAIT_MAX);
        if (!rdata_vld) begin
            $display("Timeout at %0t: no read valid for address %h", $time, a);
            timeouts++;
        end
    endtask

    // only with an empty pipeline
    task automatic pulse_mode(int kind);
        wait_idle();
        case (kind)
            P_EFUSE_DONE: efuse_done = 1'b1;
            P_TEST_ENTRY: test_entry = 1'b1;
            default:      test_exit = 1'b1;
        endcase
        next_cycle();
        drive_idle();
    endtask

    // one request per cycle on addresses 0 to 4
    task automatic random_burst(int cycles, bit with_loads);
        logic [31:0] r;
        for (int i = 0; i < cycles; i++) begin
            rng_state = xorshift32(rng_state);
            r = rng_state;
            wen = ~r[0];
            ren = r[0];
            addr = reg_addr_t'(r[15:8] % 8'd5);
            wdata = r[23:16];
            if (with_loads) begin
                stat_lgc_wen = (r[26:25] == 2'd0) ? (8'h01 << r[31:29]) : '0;
                stat_lgc_wdata = r[31:24];
                trim_lgc_wen = (r[28:27] == 2'd0) ? 8'h80 : '0;
                trim_lgc_wdata = r[31:24] ^ r[7:0];
            end
            next_cycle();
        end
        drive_idle();
        wait_idle();
    endtask

    // ====================
    // test sequence
    // ====================
    initial begin
        rng_state = SEED;
        timeouts = 0;
        spi_en = 1'b0;
        drive_idle();
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        next_cycle();

        // eFuse load lets the CPU write trim only and read nothing
        write_reg(ADDR_TRIM, 8'h5a);
        write_reg(ADDR_CTRL, 8'h33);
        write_reg(ADDR_GAIN, 8'h44);
        for (int a = 0; a < 5; a++) begin
            read_and_wait(reg_addr_t'(a));
        end

        // spi level adds its own access while eFuse still loads
        spi_en = 1'b1;
        write_reg(ADDR_CTRL, 8'h77);
        write_reg(ADDR_GAIN, 8'h88);
        write_reg(ADDR_STAT, 8'h99);
        for (int a = 0; a < 5; a++) begin
            read_and_wait(reg_addr_t'(a));
        end
        spi_en = 1'b0;

        // configuration
        pulse_mode(P_EFUSE_DONE);
        random_burst(60, 1'b0);
        read_and_wait(8'h07);
        write_reg(ADDR_CTRL, 8'hc3);
        read_and_wait(ADDR_CTRL);
        write_reg(ADDR_GAIN, 8'h3c);
        read_and_wait(ADDR_GAIN);
        stat_lgc_wen = 8'h04;
        stat_lgc_wdata = 8'ha5;
        trim_lgc_wen = 8'h10;
        trim_lgc_wdata = 8'h21;
        next_cycle();
        drive_idle();
        read_and_wait(ADDR_STAT);
        read_and_wait(ADDR_TRIM);

        // test mode opens every register
        pulse_mode(P_TEST_ENTRY);
        random_burst(60, 1'b1);
        // load lands on the edge of the cpu write
        write_reg(ADDR_STAT, 8'h3e);
        stat_lgc_wen = 8'h01;
        stat_lgc_wdata = 8'hee;
        next_cycle();
        drive_idle();
        write_reg(ADDR_TRIM, 8'h69);
        trim_lgc_wen = 8'h02;
        trim_lgc_wdata = 8'h96;
        next_cycle();
        drive_idle();
        read_and_wait(ADDR_STAT);
        read_and_wait(ADDR_TRIM);

        // back to configuration and then with spi access
        pulse_mode(P_TEST_EXIT);
        random_burst(30, 1'b1);
        spi_en = 1'b1;
        random_burst(60, 1'b1);
        spi_en = 1'b0;
        random_burst(20, 1'b0);
        repeat (2) next_cycle();

        assert_fails = u_regbank_top.u_regbank_properties.fail_count;
        $display("checker errors %0d, timeouts %0d, assertion failures %0d",
                 chk_errors, timeouts, assert_fails);
        if (chk_errors == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- bench/regbank_checker.sv
/*
 * regbank_checker
 * compares register outputs and mode with the reference model every
 * cycle, and read data against a queue of expected words
 */
module regbank_checker
    import regbank_pkg::*, access_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  reg_data_t    i_dut_ctrl,
    input  reg_data_t    i_dut_trim,
    input  reg_data_t    i_dut_gain,
    input  reg_data_t    i_dut_stat,
    input  access_mode_e i_dut_mode,
    input  reg_data_t    i_dut_rdata,
    input  logic         i_dut_rdata_vld,
    input  reg_data_t    i_exp_ctrl,
    input  reg_data_t    i_exp_trim,
    input  reg_data_t    i_exp_gain,
    input  reg_data_t    i_exp_stat,
    input  access_mode_e i_exp_mode,
    input  logic         i_exp_push,
    input  reg_data_t    i_exp_rdata,
    output int           o_errors
);
    timeunit 1ns;
    timeprecision 100ps;

    // expected read words, oldest first
    reg_data_t exp_q [$];
    reg_data_t exp_word;

    initial o_errors = 0;

    task automatic compare_word(string what, reg_data_t got, reg_data_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            o_errors++;
        end
    endtask

    // ====================
    // mid-cycle compare
    // ====================
    // DUT and model both settled after the rising edge
    always @(negedge i_clk) begin
        if (i_rst_n) begin
            compare_word("ctrl", i_dut_ctrl, i_exp_ctrl);
            compare_word("trim", i_dut_trim, i_exp_trim);
            compare_word("gain", i_dut_gain, i_exp_gain);
            compare_word("stat", i_dut_stat, i_exp_stat);
            if (i_dut_mode !== i_exp_mode) begin
                $display("Mismatch at %0t: mode is %0d, expected %0d",
                         $time, i_dut_mode, i_exp_mode);
                o_errors++;
            end
            // model resolved a read at this edge
            if (i_exp_push) begin
                exp_q.push_back(i_exp_rdata);
            end
            if (i_dut_rdata_vld) begin
                if (exp_q.size() == 0) begin
                    $display("Error at %0t: read valid with no read outstanding", $time);
                    o_errors++;
                end else begin
                    exp_word = exp_q.pop_front();
                    compare_word("rdata", i_dut_rdata, exp_word);
                end
            end else if (exp_q.size() != 0) begin
                $display("Error at %0t: read valid missing for an issued read", $time);
                o_errors++;
                exp_q.delete();
            end
        end
    end

endmodule

//--- bench/regbank_properties.sv
/*
 * regbank_properties
 * read data and mode enable assertions for the register bank
 */
module regbank_properties
    import regbank_pkg::*;
(
    input logic      i_clk,
    input logic      i_rst_n,
    input logic      i_ren,
    input reg_data_t i_rdata,
    input logic      i_rdata_vld,
    input logic      i_test_en,
    input logic      i_cfg_en,
    input logic      i_efuse_en
);
    timeunit 1ns;
    timeprecision 100ps;

    // failures seen so far, read back by the testbench
    int fail_count = 0;

    // read data stays clear between valid pulses
    a_rdata_idle_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_rdata_vld |-> (i_rdata == '0))
        else begin
            $error("read data not zero while valid is low");
            fail_count++;
        end

    // capture edge, then read data edge
    a_vld_after_read: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_ren |-> ##2 i_rdata_vld)
        else begin
            $error("read valid missing two edges after a read strobe");
            fail_count++;
        end

    // exactly one mode active
    a_mode_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot({i_test_en, i_cfg_en, i_efuse_en}))
        else begin
            $error("mode enables are not one-hot");
            fail_count++;
        end

endmodule

//--- logic/regbank_top.sv
/*
 * regbank_top
 * four-register control bank, request capture, mode machine and
 * registers, then registered read data
 */
module regbank_top
    import regbank_pkg::*, access_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_wen,
    input  logic         i_ren,
    input  reg_addr_t    i_addr,
    input  reg_data_t    i_wdata,
    input  logic         i_spi_en,
    input  logic         i_efuse_done,
    input  logic         i_test_entry,
    input  logic         i_test_exit,
    input  reg_data_t    i_stat_lgc_wen,
    input  reg_data_t    i_stat_lgc_wdata,
    input  reg_data_t    i_trim_lgc_wen,
    input  reg_data_t    i_trim_lgc_wdata,
    output reg_data_t    o_rdata,
    output logic         o_rdata_vld,
    output reg_data_t    o_ctrl,
    output reg_data_t    o_trim,
    output reg_data_t    o_gain,
    output reg_data_t    o_stat,
    output access_mode_e o_mode
);

    // captured request
    logic      req_wen;
    logic      req_ren;
    reg_addr_t req_addr;
    reg_data_t req_wdata;
    // mode levels
    logic      test_en;
    logic      cfg_en;
    logic      efuse_en;
    // per-register read words
    reg_data_t rdata_ctrl;
    reg_data_t rdata_trim;
    reg_data_t rdata_gain;
    reg_data_t rdata_stat;

    // ====================
    // stage 1, capture
    // ====================
    cpu_req_stage u_cpu_req_stage (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_wen   (i_wen),
        .i_ren   (i_ren),
        .i_addr  (i_addr),
        .i_wdata (i_wdata),
        .o_wen   (req_wen),
        .o_ren   (req_ren),
        .o_addr  (req_addr),
        .o_wdata (req_wdata)
    );

    // ====================
    // stage 2, registers
    // ====================
    access_mode_fsm u_access_mode_fsm (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_efuse_done (i_efuse_done),
        .i_test_entry (i_test_entry),
        .i_test_exit  (i_test_exit),
        .o_test_en    (test_en),
        .o_cfg_en     (cfg_en),
        .o_efuse_en   (efuse_en),
        .o_mode       (o_mode)
    );

    // ctrl, no logic load
    rww_reg #(
        .DEFAULT_VAL          (DEF_CTRL),
        .REG_ADDR             (ADDR_CTRL),
        .SUPPORT_TEST_MODE_WR (PERM_CTRL_TEST_WR),
        .SUPPORT_TEST_MODE_RD (PERM_CTRL_TEST_RD),
        .SUPPORT_CFG_MODE_WR  (PERM_CTRL_CFG_WR),
        .SUPPORT_CFG_MODE_RD  (PERM_CTRL_CFG_RD),
        .SUPPORT_SPI_EN_WR    (PERM_CTRL_SPI_WR),
        .SUPPORT_SPI_EN_RD    (PERM_CTRL_SPI_RD),
        .SUPPORT_EFUSE_WR     (PERM_CTRL_EFUSE_WR)
    ) u_reg_ctrl (
        .i_clk               (i_clk),
        .i_rst_n             (i_rst_n),
        .i_wen               (req_wen),
        .i_ren               (req_ren),
        .i_test_st_reg_en    (test_en),
        .i_cfg_st_reg_en     (cfg_en),
        .i_spi_ctrl_reg_en   (i_spi_en),
        .i_efuse_ctrl_reg_en (efuse_en),
        .i_addr              (req_addr),
        .i_wdata             (req_wdata),
        .i_lgc_wen           ('0),
        .i_lgc_wdata         ('0),
        .o_rdata             (rdata_ctrl),
        .o_reg_data          (o_ctrl)
    );

    // trim, loaded by eFuse logic
    rww_reg #(
        .DEFAULT_VAL          (DEF_TRIM),
        .REG_ADDR             (ADDR_TRIM),
        .SUPPORT_TEST_MODE_WR (PERM_TRIM_TEST_WR),
        .SUPPORT_TEST_MODE_RD (PERM_TRIM_TEST_RD),
        .SUPPORT_CFG_MODE_WR  (PERM_TRIM_CFG_WR),
        .SUPPORT_CFG_MODE_RD  (PERM_TRIM_CFG_RD),
        .SUPPORT_SPI_EN_WR    (PERM_TRIM_SPI_WR),
        .SUPPORT_SPI_EN_RD    (PERM_TRIM_SPI_RD),
        .SUPPORT_EFUSE_WR     (PERM_TRIM_EFUSE_WR)
    ) u_reg_trim (
        .i_clk               (i_clk),
        .i_rst_n             (i_rst_n),
        .i_wen               (req_wen),
        .i_ren               (req_ren),
        .i_test_st_reg_en    (test_en),
        .i_cfg_st_reg_en     (cfg_en),
        .i_spi_ctrl_reg_en   (i_spi_en),
        .i_efuse_ctrl_reg_en (efuse_en),
        .i_addr              (req_addr),
        .i_wdata             (req_wdata),
        .i_lgc_wen           (i_trim_lgc_wen),
        .i_lgc_wdata         (i_trim_lgc_wdata),
        .o_rdata             (rdata_trim),
        .o_reg_data          (o_trim)
    );

    // gain, no logic load
    rww_reg #(
        .DEFAULT_VAL          (DEF_GAIN),
        .REG_ADDR             (ADDR_GAIN),
        .SUPPORT_TEST_MODE_WR (PERM_GAIN_TEST_WR),
        .SUPPORT_TEST_MODE_RD (PERM_GAIN_TEST_RD),
        .SUPPORT_CFG_MODE_WR  (PERM_GAIN_CFG_WR),
        .SUPPORT_CFG_MODE_RD  (PERM_GAIN_CFG_RD),
        .SUPPORT_SPI_EN_WR    (PERM_GAIN_SPI_WR),
        .SUPPORT_SPI_EN_RD    (PERM_GAIN_SPI_RD),
        .SUPPORT_EFUSE_WR     (PERM_GAIN_EFUSE_WR)
    ) u_reg_gain (
        .i_clk               (i_clk),
        .i_rst_n             (i_rst_n),
        .i_wen               (req_wen),
        .i_ren               (req_ren),
        .i_test_st_reg_en    (test_en),
        .i_cfg_st_reg_en     (cfg_en),
        .i_spi_ctrl_reg_en   (i_spi_en),
        .i_efuse_ctrl_reg_en (efuse_en),
        .i_addr              (req_addr),
        .i_wdata             (req_wdata),
        .i_lgc_wen           ('0),
        .i_lgc_wdata         ('0),
        .o_rdata             (rdata_gain),
        .o_reg_data          (o_gain)
    );

    // status, set by on-chip logic
    rww_reg #(
        .DEFAULT_VAL          (DEF_STAT),
        .REG_ADDR             (ADDR_STAT),
        .SUPPORT_TEST_MODE_WR (PERM_STAT_TEST_WR),
        .SUPPORT_TEST_MODE_RD (PERM_STAT_TEST_RD),
        .SUPPORT_CFG_MODE_WR  (PERM_STAT_CFG_WR),
        .SUPPORT_CFG_MODE_RD  (PERM_STAT_CFG_RD),
        .SUPPORT_SPI_EN_WR    (PERM_STAT_SPI_WR),
        .SUPPORT_SPI_EN_RD    (PERM_STAT_SPI_RD),
        .SUPPORT_EFUSE_WR     (PERM_STAT_EFUSE_WR)
    ) u_reg_stat (
        .i_clk               (i_clk),
        .i_rst_n             (i_rst_n),
        .i_wen               (req_wen),
        .i_ren               (req_ren),
        .i_test_st_reg_en    (test_en),
        .i_cfg_st_reg_en     (cfg_en),
        .i_spi_ctrl_reg_en   (i_spi_en),
        .i_efuse_ctrl_reg_en (efuse_en),
        .i_addr              (req_addr),
        .i_wdata             (req_wdata),
        .i_lgc_wen           (i_stat_lgc_wen),
        .i_lgc_wdata         (i_stat_lgc_wdata),
        .o_rdata             (rdata_stat),
        .o_reg_data          (o_stat)
    );

    // ====================
    // stage 3, read data
    // ====================
    rdata_stage u_rdata_stage (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_ren        (req_ren),
        .i_rdata_ctrl (rdata_ctrl),
        .i_rdata_trim (rdata_trim),
        .i_rdata_gain (rdata_gain),
        .i_rdata_stat (rdata_stat),
        .o_rdata      (o_rdata),
        .o_rdata_vld  (o_rdata_vld)
    );

endmodule

//--- logic/rdata_stage.sv
/*
 * rdata_stage
 * merges the register read words and returns them one cycle later
 * with a valid pulse
 */
module rdata_stage
    import regbank_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_ren,
    input  reg_data_t i_rdata_ctrl,
    input  reg_data_t i_rdata_trim,
    input  reg_data_t i_rdata_gain,
    input  reg_data_t i_rdata_stat,
    output reg_data_t o_rdata,
    output logic      o_rdata_vld
);

    reg_data_t rdata_or;

    // at most one word is non-zero
    assign rdata_or = i_rdata_ctrl | i_rdata_trim | i_rdata_gain | i_rdata_stat;

    // valid follows every read strobe, denied or unmapped ones too
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rdata_vld <= 1'b0;
            o_rdata     <= '0;
        end else begin
            o_rdata_vld <= i_ren;
            o_rdata     <= rdata_or;
        end
    end

endmodule

//--- logic/rww_reg.sv
/*
 * rww_reg
 * one control register, CPU read/write and logic load, with CPU
 * access gated by the active mode enables
 */
module rww_reg
    import regbank_pkg::*;
#(
    parameter reg_data_t DEFAULT_VAL          = '0,
    parameter reg_addr_t REG_ADDR             = '0,
    parameter bit        SUPPORT_TEST_MODE_WR = 1'b1,
    parameter bit        SUPPORT_TEST_MODE_RD = 1'b1,
    parameter bit        SUPPORT_CFG_MODE_WR  = 1'b1,
    parameter bit        SUPPORT_CFG_MODE_RD  = 1'b1,
    parameter bit        SUPPORT_SPI_EN_WR    = 1'b1,
    parameter bit        SUPPORT_SPI_EN_RD    = 1'b1,
    parameter bit        SUPPORT_EFUSE_WR     = 1'b1
) (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_wen,
    input  logic      i_ren,
    input  logic      i_test_st_reg_en,
    input  logic      i_cfg_st_reg_en,
    input  logic      i_spi_ctrl_reg_en,
    input  logic      i_efuse_ctrl_reg_en,
    input  reg_addr_t i_addr,
    input  reg_data_t i_wdata,
    input  reg_data_t i_lgc_wen,
    input  reg_data_t i_lgc_wdata,
    output reg_data_t o_rdata,
    output reg_data_t o_reg_data
);

    logic      hit;
    logic      wr_ok;
    logic      rd_ok;
    logic      cpu_wr;
    logic      cpu_rd;
    reg_data_t reg_data;

    // ====================
    // access decode
    // ====================
    assign hit = (i_addr == REG_ADDR);

    // any active mode that allows it is enough
    assign wr_ok = (i_test_st_reg_en    & SUPPORT_TEST_MODE_WR) |
                   (i_cfg_st_reg_en     & SUPPORT_CFG_MODE_WR)  |
                   (i_spi_ctrl_reg_en   & SUPPORT_SPI_EN_WR)    |
                   (i_efuse_ctrl_reg_en & SUPPORT_EFUSE_WR);
    // no eFuse term, it never reads
    assign rd_ok = (i_test_st_reg_en  & SUPPORT_TEST_MODE_RD) |
                   (i_cfg_st_reg_en   & SUPPORT_CFG_MODE_RD)  |
                   (i_spi_ctrl_reg_en & SUPPORT_SPI_EN_RD);

    assign cpu_wr = i_wen & hit & wr_ok;
    assign cpu_rd = i_ren & hit & rd_ok;

    // ====================
    // storage
    // ====================
    // cpu write beats a logic load at the same edge
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            reg_data <= DEFAULT_VAL;
        end else if (cpu_wr) begin
            reg_data <= i_wdata;
        end else if (|i_lgc_wen) begin
            // any enable bit loads the full word
            reg_data <= i_lgc_wdata;
        end
    end

    assign o_reg_data = reg_data;
    // zero unless selected, so the read mux is a plain OR
    assign o_rdata = cpu_rd ? reg_data : '0;

endmodule

//--- logic/access_mode_fsm.sv
/*
 * access_mode_fsm
 * chip access mode, eFuse load after reset, then configuration,
 * with entry and exit of test mode
 */
module access_mode_fsm
    import access_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_efuse_done,
    input  logic         i_test_entry,
    input  logic         i_test_exit,
    output logic         o_test_en,
    output logic         o_cfg_en,
    output logic         o_efuse_en,
    output access_mode_e o_mode
);

    access_mode_e state;
    access_mode_e state_next;

    // ====================
    // next state
    // ====================
    always_comb begin
        state_next = state;
        case (state)
            // wait for eFuse shadow load
            MODE_EFUSE: if (i_efuse_done) state_next = MODE_CFG;
            MODE_CFG:   if (i_test_entry) state_next = MODE_TEST;
            MODE_TEST:  if (i_test_exit)  state_next = MODE_CFG;
            // unused code, fall back to the safe mode
            default:    state_next = MODE_EFUSE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= MODE_EFUSE;
        end else begin
            state <= state_next;
        end
    end

    // ====================
    // one-hot enables
    // ====================
    assign o_efuse_en = (state == MODE_EFUSE);
    assign o_cfg_en   = (state == MODE_CFG);
    assign o_test_en  = (state == MODE_TEST);

    // status copy
    assign o_mode = state;

endmodule

//--- logic/cpu_req_stage.sv
/*
 * cpu_req_stage
 * capture stage for the CPU bus, registers strobes, address and
 * write data ahead of the register decode
 */
module cpu_req_stage
    import regbank_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_wen,
    input  logic      i_ren,
    input  reg_addr_t i_addr,
    input  reg_data_t i_wdata,
    output logic      o_wen,
    output logic      o_ren,
    output reg_addr_t o_addr,
    output reg_data_t o_wdata
);

    // strobes, cleared on reset
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wen <= 1'b0;
            o_ren <= 1'b0;
        end else begin
            o_wen <= i_wen;
            o_ren <= i_ren;
        end
    end

    // payload, only meaningful with a strobe
    always_ff @(posedge i_clk) begin
        o_addr  <= i_addr;
        o_wdata <= i_wdata;
    end

endmodule

//--- logic/access_pkg.sv
/*
 * access_pkg
 * chip access modes and per-register access permissions
 */
package access_pkg;

    // mode machine states
    typedef enum logic [1:0] {
        MODE_EFUSE = 2'd0,
        MODE_CFG   = 2'd1,
        MODE_TEST  = 2'd2
    } access_mode_e;

    // ====================
    // permissions
    // ====================
    // one bit per source, eFuse never reads
    localparam bit PERM_CTRL_TEST_WR  = 1'b1;
    localparam bit PERM_CTRL_TEST_RD  = 1'b1;
    localparam bit PERM_CTRL_CFG_WR   = 1'b1;
    localparam bit PERM_CTRL_CFG_RD   = 1'b1;
    localparam bit PERM_CTRL_SPI_WR   = 1'b1;
    localparam bit PERM_CTRL_SPI_RD   = 1'b1;
    localparam bit PERM_CTRL_EFUSE_WR = 1'b0;

    // trim is the eFuse target, read-only for cfg
    localparam bit PERM_TRIM_TEST_WR  = 1'b1;
    localparam bit PERM_TRIM_TEST_RD  = 1'b1;
    localparam bit PERM_TRIM_CFG_WR   = 1'b0;
    localparam bit PERM_TRIM_CFG_RD   = 1'b1;
    localparam bit PERM_TRIM_SPI_WR   = 1'b0;
    localparam bit PERM_TRIM_SPI_RD   = 1'b0;
    localparam bit PERM_TRIM_EFUSE_WR = 1'b1;

    localparam bit PERM_GAIN_TEST_WR  = 1'b1;
    localparam bit PERM_GAIN_TEST_RD  = 1'b1;
    localparam bit PERM_GAIN_CFG_WR   = 1'b1;
    localparam bit PERM_GAIN_CFG_RD   = 1'b1;
    localparam bit PERM_GAIN_SPI_WR   = 1'b1;
    localparam bit PERM_GAIN_SPI_RD   = 1'b1;
    localparam bit PERM_GAIN_EFUSE_WR = 1'b0;

    // status only writable in test mode
    localparam bit PERM_STAT_TEST_WR  = 1'b1;
    localparam bit PERM_STAT_TEST_RD  = 1'b1;
    localparam bit PERM_STAT_CFG_WR   = 1'b0;
    localparam bit PERM_STAT_CFG_RD   = 1'b1;
    localparam bit PERM_STAT_SPI_WR   = 1'b0;
    localparam bit PERM_STAT_SPI_RD   = 1'b1;
    localparam bit PERM_STAT_EFUSE_WR = 1'b0;

endpackage

//--- logic/regbank_pkg.sv
/*
 * regbank_pkg
 * widths, word types, register map and reset values of the control
 * register bank
 */
package regbank_pkg;

    // ====================
    // widths
    // ====================
    localparam int REG_DW = 8;
    localparam int REG_AW = 8;

    // one data word, one register address
    typedef logic [REG_DW-1:0] reg_data_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    // ====================
    // register map
    // ====================
    localparam reg_addr_t ADDR_CTRL = 8'h00;
    localparam reg_addr_t ADDR_TRIM = 8'h01;
    localparam reg_addr_t ADDR_GAIN = 8'h02;
    localparam reg_addr_t ADDR_STAT = 8'h03;

    // ====================
    // reset values
    // ====================
    // trim sits mid-scale until eFuse or CPU loads it
    localparam reg_data_t DEF_CTRL = 8'h00;
    localparam reg_data_t DEF_TRIM = 8'h80;
    localparam reg_data_t DEF_GAIN = 8'h10;
    localparam reg_data_t DEF_STAT = 8'h00;

endpackage
